// File: rtl/sysid_bus_pkg.sv
package sysid_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register bus widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte offset into the register window
  localparam int addr_width = 6;
  localparam int data_width = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Register offset map, one word each
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [addr_width-1:0] off_id     = 6'h00;
  localparam logic [addr_width-1:0] off_dna_lo = 6'h08;
  localparam logic [addr_width-1:0] off_dna_hi = 6'h0c;
  localparam logic [addr_width-1:0] off_hash0  = 6'h10;
  localparam logic [addr_width-1:0] off_hash1  = 6'h14;
  localparam logic [addr_width-1:0] off_hash2  = 6'h18;
  localparam logic [addr_width-1:0] off_hash3  = 6'h1c;
  // Last hash word sits apart from the others
  localparam logic [addr_width-1:0] off_hash4  = 6'h2c;

  // Register select from decode to read mux
  typedef enum logic [3:0] {
    sel_id, sel_dna_lo, sel_dna_hi,
    sel_hash0, sel_hash1, sel_hash2, sel_hash3, sel_hash4,
    sel_none
  } reg_sel_e;

endpackage

// File: rtl/sysid_dna_pkg.sv
package sysid_dna_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Device DNA geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int dna_bits = 57;

  // Upper DNA bits that land in the high status word
  localparam int dna_hi_bits = dna_bits - sysid_bus_pkg::data_width;

  // Zero fill between busy and the DNA bits
  localparam int dna_rsvd_bits = sysid_bus_pkg::data_width - 1 - dna_hi_bits;

  ////////////////////////////////////////////////////////////////////////////
  // Readout sequencing counts
  ////////////////////////////////////////////////////////////////////////////

  // Load strobe held while the counter is below this
  localparam int read_end    = 10;
  // Shift enabled from this count on
  localparam int shift_start = 19;
  // Sequence finished at this count
  localparam int done_count  = 466;

  ////////////////////////////////////////////////////////////////////////////
  // DNA-high status word
  ////////////////////////////////////////////////////////////////////////////

  // Bus side sees raw, builders and checkers use fields
  typedef union packed {
    logic [sysid_bus_pkg::data_width-1:0] raw;
    struct packed {
      // Readout still running
      logic                     busy;
      logic [dna_rsvd_bits-1:0] reserved;
      // DNA bits 56 down to 32
      logic [dna_hi_bits-1:0]   dna_hi;
    } fields;
  } dna_hi_word_u;

endpackage

// File: rtl/dna_port_model.sv
`timescale 1ns/1ps

module dna_port_model #(
  parameter logic [sysid_dna_pkg::dna_bits-1:0] sim_dna = 57'h0823456789ABCDE
) (
  input  logic clk_dna,
  input  logic read,
  input  logic shift,
  output logic dout
);

  import sysid_dna_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Behavioral stand-in for the vendor DNA shift register
  ////////////////////////////////////////////////////////////////////////////

  // Factory value plus shift state
  logic [dna_bits-1:0] dna_sr;

  // Everything happens on the slow DNA clock
  always_ff @(posedge clk_dna) begin
    if (read) begin
      // Load the fused value
      dna_sr <= sim_dna;
    end else if (shift) begin
      // Walk toward the MSB, zero fill at the bottom
      dna_sr <= {dna_sr[dna_bits-2:0], 1'b0};
    end
  end

  // MSB first, same order the reader collects
  assign dout = dna_sr[dna_bits-1];

endmodule

// File: rtl/dna_reader.sv
`timescale 1ns/1ps

module dna_reader (
  input  logic                                bus,
  input  logic                                reset,
  input  logic                                dna_dout,
  output logic                                dna_clk,
  output logic                                dna_read,
  output logic                                dna_shift,
  output logic [sysid_dna_pkg::dna_bits-1:0]  dna_value,
  output logic                                dna_done
);

  import sysid_dna_pkg::*;

  // Wide enough to reach the final count
  localparam int cnt_width = $clog2(done_count + 1);

  logic [cnt_width-1:0] dna_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Sequence counter and port strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      dna_cnt   <= '0;
      dna_clk   <= 1'b0;
      dna_read  <= 1'b0;
      dna_shift <= 1'b0;
      dna_done  <= 1'b0;
    end else begin
      // Freeze once the readout is complete
      if (!dna_done) begin
        dna_cnt <= dna_cnt + 1'b1;
      end
      // Slow clock, one period per eight counts
      dna_clk   <= dna_cnt[2];
      // Load window at the start
      dna_read  <= (dna_cnt < cnt_width'(read_end));
      dna_shift <= (dna_cnt >= cnt_width'(shift_start));
      if (dna_cnt >= cnt_width'(done_count)) begin
        dna_done <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Serial capture
  ////////////////////////////////////////////////////////////////////////////

  // Sample late in the high phase of the DNA clock, MSB first
  always_ff @(posedge bus) begin
    if (reset) begin
      dna_value <= '0;
    end else if ((dna_cnt[2:0] == 3'd0) && !dna_done) begin
      dna_value <= {dna_value[dna_bits-2:0], dna_dout};
    end
  end

endmodule

// File: rtl/sysid_addr_decode.sv
`timescale 1ns/1ps

module sysid_addr_decode (
  input  logic                                  bus,
  input  logic                                  reset,
  input  logic                                  req,
  input  logic                                  wen,
  input  logic [sysid_bus_pkg::addr_width-1:0]  addr,
  input  logic                                  ack_level,
  output sysid_bus_pkg::reg_sel_e               sel,
  output logic                                  req_err,
  output logic                                  go
);

  import sysid_bus_pkg::*;

  // A transaction is in flight until both req and ack are low
  logic pending;
  logic accept;

  // Decoded select for the current address
  reg_sel_e addr_sel;

  // New request only with the bus fully idle
  assign accept = req && !pending && !ack_level;

  ////////////////////////////////////////////////////////////////////////////
  // Offset map
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (addr)
      off_id:     addr_sel = sel_id;
      off_dna_lo: addr_sel = sel_dna_lo;
      off_dna_hi: addr_sel = sel_dna_hi;
      off_hash0:  addr_sel = sel_hash0;
      off_hash1:  addr_sel = sel_hash1;
      off_hash2:  addr_sel = sel_hash2;
      off_hash3:  addr_sel = sel_hash3;
      off_hash4:  addr_sel = sel_hash4;
      default:    addr_sel = sel_none;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      pending <= 1'b0;
      go      <= 1'b0;
      sel     <= sel_none;
      req_err <= 1'b0;
    end else begin
      go <= accept;
      if (accept) begin
        pending <= 1'b1;
        // Registers are read only, so writes fail
        sel     <= wen ? sel_none : addr_sel;
        req_err <= wen || (addr_sel == sel_none);
      end else if (!req && !ack_level) begin
        // Handshake back at idle
        pending <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/sysid_read_mux.sv
`timescale 1ns/1ps

module sysid_read_mux #(
  parameter logic [sysid_bus_pkg::data_width-1:0]   id_value = 32'h1,
  parameter logic [5*sysid_bus_pkg::data_width-1:0] git_hash = '0
) (
  input  logic                                  bus,
  input  logic                                  reset,
  input  logic                                  go,
  input  sysid_bus_pkg::reg_sel_e               sel,
  input  logic                                  req_err,
  input  logic                                  req,
  input  logic [sysid_dna_pkg::dna_bits-1:0]    dna_value,
  input  logic                                  dna_done,
  output logic [sysid_bus_pkg::data_width-1:0]  rdata,
  output logic                                  ack,
  output logic                                  err
);

  import sysid_bus_pkg::*;
  import sysid_dna_pkg::*;

  dna_hi_word_u            hi_word;
  logic [data_width-1:0]   sel_word;

  ////////////////////////////////////////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////////////////////////////////////////

  // Status word, busy until the readout finishes
  always_comb begin
    hi_word.fields.busy     = !dna_done;
    hi_word.fields.reserved = '0;
    hi_word.fields.dna_hi   = dna_value[dna_bits-1:data_width];
  end

  always_comb begin
    case (sel)
      sel_id:     sel_word = id_value;
      sel_dna_lo: sel_word = dna_value[data_width-1:0];
      sel_dna_hi: sel_word = hi_word.raw;
      sel_hash0:  sel_word = git_hash[0*data_width +: data_width];
      sel_hash1:  sel_word = git_hash[1*data_width +: data_width];
      sel_hash2:  sel_word = git_hash[2*data_width +: data_width];
      sel_hash3:  sel_word = git_hash[3*data_width +: data_width];
      sel_hash4:  sel_word = git_hash[4*data_width +: data_width];
      // Errored or unmapped access
      default:    sel_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response and ack phases
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      rdata <= '0;
      err   <= 1'b0;
      ack   <= 1'b0;
    end else if (go) begin
      // Data and err valid together with ack
      rdata <= sel_word;
      err   <= req_err;
      ack   <= 1'b1;
    end else if (ack && !req) begin
      // Master released req
      ack <= 1'b0;
    end
  end

endmodule

// File: rtl/sysid_top.sv
`timescale 1ns/1ps

module sysid_top #(
  parameter logic [sysid_bus_pkg::data_width-1:0]   id_value = 32'h1,
  parameter logic [5*sysid_bus_pkg::data_width-1:0] git_hash = '0,
  parameter logic [sysid_dna_pkg::dna_bits-1:0]     sim_dna  = 57'h0823456789ABCDE
) (
  input  logic                                  bus,
  input  logic                                  reset,
  input  logic                                  req,
  input  logic                                  wen,
  input  logic [sysid_bus_pkg::addr_width-1:0]  addr,
  output logic [sysid_bus_pkg::data_width-1:0]  rdata,
  output logic                                  ack,
  output logic                                  err
);

  import sysid_bus_pkg::*;
  import sysid_dna_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  // Decode to mux
  reg_sel_e             sel;
  logic                 req_err;
  logic                 go;

  // DNA port strobes and data
  logic                 dna_clk;
  logic                 dna_read;
  logic                 dna_shift;
  logic                 dna_dout;
  logic [dna_bits-1:0]  dna_value;
  logic                 dna_done;

  sysid_addr_decode sysid_addr_decode_i (
    .bus       (bus),
    .reset     (reset),
    .req       (req),
    .wen       (wen),
    .addr      (addr),
    .ack_level (ack),
    .sel       (sel),
    .req_err   (req_err),
    .go        (go)
  );

  dna_reader dna_reader_i (
    .bus       (bus),
    .reset     (reset),
    .dna_dout  (dna_dout),
    .dna_clk   (dna_clk),
    .dna_read  (dna_read),
    .dna_shift (dna_shift),
    .dna_value (dna_value),
    .dna_done  (dna_done)
  );

  // Simulation model of the device DNA
  dna_port_model #(
    .sim_dna (sim_dna)
  ) dna_port_model_i (
    .clk_dna (dna_clk),
    .read    (dna_read),
    .shift   (dna_shift),
    .dout    (dna_dout)
  );

  sysid_read_mux #(
    .id_value (id_value),
    .git_hash (git_hash)
  ) sysid_read_mux_i (
    .bus       (bus),
    .reset     (reset),
    .go        (go),
    .sel       (sel),
    .req_err   (req_err),
    .req       (req),
    .dna_value (dna_value),
    .dna_done  (dna_done),
    .rdata     (rdata),
    .ack       (ack),
    .err       (err)
  );

endmodule

// File: verif/sysid_tb.sv
`timescale 1ns/1ps

module sysid_tb;

  import sysid_bus_pkg::*;
  import sysid_dna_pkg::*;

  // Build values, the stimulus file expects these
  localparam logic [data_width-1:0]   test_id_value = 32'h51d00102;
  localparam logic [5*data_width-1:0] test_git_hash =
    160'h89abcdef_01234567_deadbeef_cafef00d_5a5aa5a5;
  localparam logic [dna_bits-1:0]     test_sim_dna  = 57'h1a5c3f09e2d7b61;

  logic                   bus;
  logic                   reset;
  logic                   req;
  logic                   wen;
  logic [addr_width-1:0]  addr;
  logic [data_width-1:0]  rdata;
  logic                   ack;
  logic                   err;

  // One entry per stimulus row
  logic                   wr_q[$];
  logic [addr_width-1:0]  off_q[$];
  logic [data_width-1:0]  data_q[$];
  logic                   err_q[$];
  bit                     rows_loaded;

  sysid_top #(
    .id_value (test_id_value),
    .git_hash (test_git_hash),
    .sim_dna  (test_sim_dna)
  ) sysid_top_i (
    .bus   (bus),
    .reset (reset),
    .req   (req),
    .wen   (wen),
    .addr  (addr),
    .rdata (rdata),
    .ack   (ack),
    .err   (err)
  );

  // 100 ns period
  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure exit and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input logic [data_width-1:0] exp,
                              input logic [data_width-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic compare_dna_hi(input dna_hi_word_u exp, input dna_hi_word_u act);
    if (act.fields.busy !== exp.fields.busy) begin
      stop_run($sformatf("[FAIL] rdata.busy expected 0x%0h actual 0x%0h",
                         exp.fields.busy, act.fields.busy));
    end
    if (act.fields.reserved !== exp.fields.reserved) begin
      stop_run($sformatf("[FAIL] rdata.reserved expected 0x%02h actual 0x%02h",
                         exp.fields.reserved, act.fields.reserved));
    end
    // Partial DNA still moving while busy
    if (!exp.fields.busy && (act.fields.dna_hi !== exp.fields.dna_hi)) begin
      stop_run($sformatf("[FAIL] rdata.dna_hi expected 0x%07h actual 0x%07h",
                         exp.fields.dna_hi, act.fields.dna_hi));
    end
  endtask

  task automatic compare_err(input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] err expected 0x%0h actual 0x%0h", exp, act));
    end
  endtask

  task automatic compare_ack(input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] ack expected 0x%0h actual 0x%0h", exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file and bus master
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_rows();
    int                    fd;
    int                    code;
    string                 tok;
    string                 rest;
    logic [addr_width-1:0] off;
    logic [data_width-1:0] data;
    logic                  er;
    bit                    at_end;
    at_end = 1'b0;
    fd = $fopen("verif/sysid_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open verif/sysid_stimulus.txt");
    end
    while (!at_end) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        at_end = 1'b1;
      end else if (tok.substr(0, 0) == "#") begin
        // Skip the rest of a comment line
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h", off, data, er);
        if ((code != 3) || ((tok != "R") && (tok != "W"))) begin
          stop_run($sformatf("Malformed stimulus row starting with %s", tok));
        end
        wr_q.push_back(tok == "W");
        off_q.push_back(off);
        data_q.push_back(data);
        err_q.push_back(er);
      end
    end
    $fclose(fd);
    rows_loaded = 1'b1;
  endtask

  // Full four-phase transfer with random gaps
  task automatic bus_transfer(input logic wr, input logic [addr_width-1:0] off,
                              output logic [data_width-1:0] data, output logic error);
    int unsigned gap;
    gap = $urandom % 4;
    // No ack may appear without req
    repeat (gap) begin
      @(posedge bus);
      compare_ack(1'b0, ack);
    end
    addr <= off;
    wen  <= wr;
    req  <= 1'b1;
    @(posedge bus);
    while (ack !== 1'b1) begin
      @(posedge bus);
    end
    // Response valid together with ack
    data  = rdata;
    error = err;
    // Slave held in the ack phase until req drops
    gap = $urandom % 4;
    repeat (gap) begin
      @(posedge bus);
      compare_ack(1'b1, ack);
    end
    req <= 1'b0;
    @(posedge bus);
    while (ack !== 1'b0) begin
      @(posedge bus);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [data_width-1:0] rd;
    logic                  rerr;
    dna_hi_word_u          exp_hi;
    dna_hi_word_u          got_hi;
    void'($urandom(23));
    reset = 1'b1;
    req   = 1'b0;
    wen   = 1'b0;
    addr  = '0;
    load_rows();
    repeat (2) @(posedge bus);
    reset <= 1'b0;
    @(posedge bus);
    // Idle outputs out of reset
    compare_ack(1'b0, ack);
    compare_err(1'b0, err);
    compare_word("rdata", '0, rdata);
    foreach (wr_q[i]) begin
      bus_transfer(wr_q[i], off_q[i], rd, rerr);
      if (!wr_q[i] && (off_q[i] == off_dna_hi)) begin
        exp_hi.raw = data_q[i];
        got_hi.raw = rd;
        // Poll on busy when the row expects a finished readout
        while (!exp_hi.fields.busy && got_hi.fields.busy) begin
          bus_transfer(1'b0, off_dna_hi, rd, rerr);
          got_hi.raw = rd;
        end
        compare_dna_hi(exp_hi, got_hi);
      end else begin
        compare_word("rdata", data_q[i], rd);
      end
      compare_err(err_q[i], rerr);
    end
    $display("Test passed");
    $finish;
  end

  // Transaction budget plus the DNA readout
  initial begin
    int limit;
    wait (rows_loaded);
    limit = (wr_q.size() + 2) * 40 + 600;
    repeat (limit) @(posedge bus);
    stop_run($sformatf("Run timed out after %0d cycles with transfers still open", limit));
  end

endmodule

// File: verif/sysid_stimulus.txt
# op offset rdata err, all hex, op R is a read and W a write
# A DNA-high read expecting busy 0 polls until the readout is done
R 0c 80000000 0
R 00 51d00102 0
R 10 5a5aa5a5 0
R 14 cafef00d 0
R 18 deadbeef 0
R 1c 01234567 0
R 2c 89abcdef 0
R 04 00000000 1
R 20 00000000 1
R 3c 00000000 1
W 00 00000000 1
R 00 51d00102 0
W 14 00000000 1
R 14 cafef00d 0
W 2c 00000000 1
W 24 00000000 1
W 3c 00000000 1
R 0c 01a5c3f0 0
R 08 9e2d7b61 0
W 08 00000000 1
R 08 9e2d7b61 0
W 0c 00000000 1
R 0c 01a5c3f0 0
R 2c 89abcdef 0
R 00 51d00102 0

// File: src.f
rtl/sysid_bus_pkg.sv
rtl/sysid_dna_pkg.sv
rtl/dna_port_model.sv
rtl/dna_reader.sv
rtl/sysid_addr_decode.sv
rtl/sysid_read_mux.sv
rtl/sysid_top.sv
verif/sysid_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the system ID testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module sysid_tb -f src.f

out=$(./obj_dir/Vsysid_tb 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed'
